// File: src/vex_pkg.sv
package vex_pkg;

    // one vector element, also the width of the scalar operand
    typedef logic [31:0] word_t;

    // vector register number
    typedef logic [4:0] vreg_idx_t;

    // raw 5-bit immediate from the instruction
    typedef logic [4:0] vimm_t;

    // per-lane byte enables, one bit per byte of an element
    typedef logic [3:0] byte_en_t;

    localparam int NUM_VREGS = 32;

    // functional unit select
    typedef enum logic {
        VFU_ALU,
        VFU_RED
    } vfu_t;

    // ALU and reduction operations
    typedef enum logic [3:0] {
        VALU_ADD,
        VALU_SUB,
        VALU_AND,
        VALU_OR,
        VALU_XOR,
        VALU_MIN,
        VALU_MAX,
        VALU_MINU,
        VALU_MAXU,
        VALU_SEQ
    } valuop_t;

endpackage

// File: src/vex_if.sv
// execute result heading into the EX/MEM register
interface vex_result_if
    import vex_pkg::*;
#(
    parameter int NUM_LANES = 4
) ();
    logic                  valid;
    vreg_idx_t             vd;
    word_t [NUM_LANES-1:0] vres;
    logic [NUM_LANES-1:0]  lane_mask;

    modport ex (output valid, vd, vres, lane_mask);
    modport mem (input valid, vd, vres, lane_mask);
endinterface

// write-back from the EX/MEM register into the lane banks
interface vex_wb_if
    import vex_pkg::*;
#(
    parameter int NUM_LANES = 4
) ();
    logic                     wen;
    vreg_idx_t                vd;
    word_t [NUM_LANES-1:0]    wdata;
    byte_en_t [NUM_LANES-1:0] byte_wen;

    modport wb (output wen, vd, wdata, byte_wen);
    modport rf (input wen, vd, wdata, byte_wen);
endinterface

// File: src/vector_bank.sv
module vector_bank
    import vex_pkg::*;
#(
    parameter int LANE = 0
) (
    input  logic      CLK,
    input  logic      rst_n,
    input  vreg_idx_t vs1,
    input  vreg_idx_t vs2,
    input  vreg_idx_t vs3,
    vex_wb_if.rf      wb,
    output word_t     vdat1,
    output word_t     vdat2,
    output word_t     vdat3,
    output word_t     v0
);

    word_t    regs [NUM_VREGS];
    word_t    wdata;
    byte_en_t wen_bytes;
    word_t    wbit_mask;

    // this lane's slice of the write-back
    assign wdata     = wb.wdata[LANE];
    assign wen_bytes = wb.wen ? wb.byte_wen[LANE] : '0;

    always_comb begin
        for (int b = 0; b < 4; b++) begin
            wbit_mask[8*b +: 8] = {8{wen_bytes[b]}};
        end
    end

    // merge pending write bytes over the stored word
    function automatic word_t fwd(word_t stored, logic hit, word_t wmask, word_t wd);
        return hit ? ((stored & ~wmask) | (wd & wmask)) : stored;
    endfunction

    assign vdat1 = fwd(regs[vs1], vs1 == wb.vd, wbit_mask, wdata);
    assign vdat2 = fwd(regs[vs2], vs2 == wb.vd, wbit_mask, wdata);
    assign vdat3 = fwd(regs[vs3], vs3 == wb.vd, wbit_mask, wdata);
    assign v0    = fwd(regs[0], wb.vd == '0, wbit_mask, wdata);

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            for (int r = 0; r < NUM_VREGS; r++) begin
                regs[r] <= '0;
            end
        end else begin
            for (int b = 0; b < 4; b++) begin
                if (wen_bytes[b]) begin
                    regs[wb.vd][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
    end

endmodule

// File: src/vlane_alu.sv
module vlane_alu
    import vex_pkg::*;
(
    input  word_t   vop_a,
    input  word_t   vop_b,
    input  valuop_t valuop,
    output word_t   vres
);

    logic lt_signed;
    logic lt_unsigned;

    assign lt_signed   = $signed(vop_a) < $signed(vop_b);
    assign lt_unsigned = vop_a < vop_b;

    always_comb begin
        case (valuop)
            VALU_ADD: begin
                vres = vop_a + vop_b;
            end
            // operand a is always vs2
            VALU_SUB: begin
                vres = vop_a - vop_b;
            end
            VALU_AND: begin
                vres = vop_a & vop_b;
            end
            VALU_OR: begin
                vres = vop_a | vop_b;
            end
            VALU_XOR: begin
                vres = vop_a ^ vop_b;
            end
            VALU_MIN: begin
                vres = lt_signed ? vop_a : vop_b;
            end
            VALU_MAX: begin
                vres = lt_signed ? vop_b : vop_a;
            end
            VALU_MINU: begin
                vres = lt_unsigned ? vop_a : vop_b;
            end
            VALU_MAXU: begin
                vres = lt_unsigned ? vop_b : vop_a;
            end
            // compare gives a plain 0/1 element
            VALU_SEQ: begin
                vres = {31'b0, vop_a == vop_b};
            end
            default: begin
                vres = '0;
            end
        endcase
    end

endmodule

// File: src/vreduction_unit.sv
module vreduction_unit
    import vex_pkg::*;
#(
    parameter int NUM_LANES = 4
) (
    input  valuop_t               valuop,
    input  word_t [NUM_LANES-1:0] vdat_in,
    input  logic [NUM_LANES-1:0]  vmask_in,
    input  word_t                 vinit,
    output word_t                 vred_res
);

    // tree width rounded up to a power of two, extra leaves are padding
    localparam int TREE_W = 1 << $clog2(NUM_LANES);

    word_t ident;
    // heap order: node 0 is the root, leaves start at TREE_W-1
    word_t node [0:2*TREE_W-2];

    // identity element per operation, fills inactive lanes
    always_comb begin
        case (valuop)
            VALU_AND, VALU_MINU: ident = '1;
            VALU_MAX:            ident = 32'h8000_0000;
            VALU_MIN:            ident = 32'h7fff_ffff;
            default:             ident = '0;
        endcase
    end

    for (genvar l = 0; l < TREE_W; l++) begin : g_leaf
        if (l < NUM_LANES) begin : g_lane
            assign node[TREE_W-1+l] = vmask_in[l] ? vdat_in[l] : ident;
        end else begin : g_pad
            assign node[TREE_W-1+l] = ident;
        end
    end

    for (genvar n = 0; n < TREE_W - 1; n++) begin : g_node
        vlane_alu u_fold (
            .vop_a  (node[2*n+1]),
            .vop_b  (node[2*n+2]),
            .valuop (valuop),
            .vres   (node[n])
        );
    end

    // element 0 of vs1 joins last
    vlane_alu u_init (
        .vop_a  (vinit),
        .vop_b  (node[0]),
        .valuop (valuop),
        .vres   (vred_res)
    );

endmodule

// File: src/vex_datapath.sv
module vex_datapath
    import vex_pkg::*;
#(
    parameter int NUM_LANES = 4
) (
    input  logic                           CLK,
    input  logic                           rst_n,
    input  logic                           vvalid,
    input  vfu_t                           vfu,
    input  valuop_t                        valuop,
    input  vreg_idx_t                      vs1_sel,
    input  vreg_idx_t                      vs2_sel,
    input  vreg_idx_t                      vd_sel,
    input  logic                           vxin1_use_imm,
    input  logic                           vxin1_use_rs1,
    input  vimm_t                          vimm,
    input  word_t                          rdat1,
    input  logic                           vmask_en,
    input  logic [$clog2(NUM_LANES+1)-1:0] vl,
    vex_result_if.ex                       res,
    vex_wb_if.rf                           wb
);

    word_t [NUM_LANES-1:0] vdat1;
    word_t [NUM_LANES-1:0] vdat2;
    word_t [NUM_LANES-1:0] vdat3;
    word_t [NUM_LANES-1:0] v0_lane;
    word_t [NUM_LANES-1:0] vop_b;
    word_t [NUM_LANES-1:0] alu_res;
    word_t                 ext_imm;
    word_t                 red_res;
    logic [NUM_LANES-1:0]  tail_mask;
    logic [NUM_LANES-1:0]  elem_mask;
    logic [NUM_LANES-1:0]  lane_mask;

    for (genvar l = 0; l < NUM_LANES; l++) begin : g_lane
        // vs3 reads the old destination for inactive lanes
        vector_bank #(.LANE(l)) u_bank (
            .CLK   (CLK),
            .rst_n (rst_n),
            .vs1   (vs1_sel),
            .vs2   (vs2_sel),
            .vs3   (vd_sel),
            .wb    (wb),
            .vdat1 (vdat1[l]),
            .vdat2 (vdat2[l]),
            .vdat3 (vdat3[l]),
            .v0    (v0_lane[l])
        );

        vlane_alu u_alu (
            .vop_a  (vdat2[l]),
            .vop_b  (vop_b[l]),
            .valuop (valuop),
            .vres   (alu_res[l])
        );
    end

    assign ext_imm = {{27{vimm[4]}}, vimm};

    // operand b: immediate, then scalar, then vs1
    always_comb begin
        if (vxin1_use_imm) begin
            vop_b = {NUM_LANES{ext_imm}};
        end else if (vxin1_use_rs1) begin
            vop_b = {NUM_LANES{rdat1}};
        end else begin
            vop_b = vdat1;
        end
    end

    always_comb begin
        for (int l = 0; l < NUM_LANES; l++) begin
            tail_mask[l] = vl > l;
        end
    end

    // mask bit i of element i sits in the low word of v0
    assign elem_mask = tail_mask & (vmask_en ? v0_lane[0][NUM_LANES-1:0] : '1);

    // a reduction only ever writes element 0
    always_comb begin
        if (vfu == VFU_RED) begin
            lane_mask    = '0;
            lane_mask[0] = tail_mask[0];
        end else begin
            lane_mask = elem_mask;
        end
    end

    vreduction_unit #(.NUM_LANES(NUM_LANES)) u_red (
        .valuop   (valuop),
        .vdat_in  (vdat2),
        .vmask_in (elem_mask),
        .vinit    (vdat1[0]),
        .vred_res (red_res)
    );

    // inactive lanes carry the old destination value
    always_comb begin
        for (int l = 0; l < NUM_LANES; l++) begin
            res.vres[l] = lane_mask[l] ? alu_res[l] : vdat3[l];
        end
        if (vfu == VFU_RED && lane_mask[0]) begin
            res.vres[0] = red_res;
        end
    end

    assign res.valid     = vvalid;
    assign res.vd        = vd_sel;
    assign res.lane_mask = lane_mask;

endmodule

// File: src/vex_mem_reg.sv
module vex_mem_reg
    import vex_pkg::*;
#(
    parameter int NUM_LANES = 4
) (
    input  logic                       CLK,
    input  logic                       rst_n,
    input  logic                       stall,
    vex_result_if.mem                  res,
    vex_wb_if.wb                       wb,
    output logic                       res_valid,
    output vreg_idx_t                  res_vd,
    output logic [32*NUM_LANES-1:0]    res_data,
    output logic [NUM_LANES-1:0]       res_lane_mask
);

    logic                  valid_q;
    vreg_idx_t             vd_q;
    word_t [NUM_LANES-1:0] data_q;
    logic [NUM_LANES-1:0]  mask_q;

    // hold everything while stalled
    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
            vd_q    <= '0;
            data_q  <= '0;
            mask_q  <= '0;
        end else if (!stall) begin
            valid_q <= res.valid;
            vd_q    <= res.vd;
            data_q  <= res.vres;
            mask_q  <= res.lane_mask;
        end
    end

    assign wb.wen   = valid_q;
    assign wb.vd    = vd_q;
    assign wb.wdata = data_q;

    // whole-element writes, one mask bit covers four bytes
    always_comb begin
        for (int l = 0; l < NUM_LANES; l++) begin
            wb.byte_wen[l] = {4{mask_q[l]}};
        end
    end

    assign res_valid     = valid_q;
    assign res_vd        = vd_q;
    assign res_data      = data_q;
    assign res_lane_mask = mask_q;

endmodule

// File: src/vex_top.sv
module vex_top
    import vex_pkg::*;
#(
    parameter int NUM_LANES = 4
) (
    input  logic                           CLK,
    input  logic                           rst_n,
    input  logic                           vvalid,
    input  vfu_t                           vfu,
    input  valuop_t                        valuop,
    input  vreg_idx_t                      vs1_sel,
    input  vreg_idx_t                      vs2_sel,
    input  vreg_idx_t                      vd_sel,
    input  logic                           vxin1_use_imm,
    input  logic                           vxin1_use_rs1,
    input  vimm_t                          vimm,
    input  word_t                          rdat1,
    input  logic                           vmask_en,
    input  logic [$clog2(NUM_LANES+1)-1:0] vl,
    input  logic                           stall,
    output logic                           res_valid,
    output vreg_idx_t                      res_vd,
    output logic [32*NUM_LANES-1:0]        res_data,
    output logic [NUM_LANES-1:0]           res_lane_mask
);

    vex_result_if #(.NUM_LANES(NUM_LANES)) res_if ();
    vex_wb_if #(.NUM_LANES(NUM_LANES)) wb_if ();

    vex_datapath #(.NUM_LANES(NUM_LANES)) u_datapath (
        .CLK           (CLK),
        .rst_n         (rst_n),
        .vvalid        (vvalid),
        .vfu           (vfu),
        .valuop        (valuop),
        .vs1_sel       (vs1_sel),
        .vs2_sel       (vs2_sel),
        .vd_sel        (vd_sel),
        .vxin1_use_imm (vxin1_use_imm),
        .vxin1_use_rs1 (vxin1_use_rs1),
        .vimm          (vimm),
        .rdat1         (rdat1),
        .vmask_en      (vmask_en),
        .vl            (vl),
        .res           (res_if.ex),
        .wb            (wb_if.rf)
    );

    vex_mem_reg #(.NUM_LANES(NUM_LANES)) u_mem_reg (
        .CLK           (CLK),
        .rst_n         (rst_n),
        .stall         (stall),
        .res           (res_if.mem),
        .wb            (wb_if.wb),
        .res_valid     (res_valid),
        .res_vd        (res_vd),
        .res_data      (res_data),
        .res_lane_mask (res_lane_mask)
    );

endmodule

// File: tb/vex_properties.sv
module vex_properties
    import vex_pkg::*;
#(
    parameter int NUM_LANES = 4
) (
    input logic                           CLK,
    input logic                           rst_n,
    input logic                           stall,
    input logic [$clog2(NUM_LANES+1)-1:0] vl,
    input logic                           res_valid,
    input vreg_idx_t                      res_vd,
    input logic [32*NUM_LANES-1:0]        res_data,
    input logic [NUM_LANES-1:0]           res_lane_mask
);

    // first cycle out of reset carries no result
    assert property (@(posedge CLK) !rst_n |=> !res_valid)
        else $error("res_valid high in the cycle after reset");

    assert property (@(posedge CLK) disable iff (!rst_n)
        stall |=> $stable(res_valid) && $stable(res_vd) && $stable(res_data)
                  && $stable(res_lane_mask))
        else $error("result outputs changed while stalled");

    // tail lanes never reach the write-back
    assert property (@(posedge CLK) disable iff (!rst_n)
        !stall |=> (res_lane_mask >> $past(vl)) == '0)
        else $error("lane mask set at or above vl");

endmodule

bind vex_top vex_properties #(.NUM_LANES(NUM_LANES)) u_props (.*);

// File: tb/vex_tb.sv
module vex_tb
    import vex_pkg::*;
();

    localparam int NUM_LANES = 4;
    localparam int VLW = $clog2(NUM_LANES + 1);
    localparam int NUM_ROWS = 28;
    // ten cycles of 4 time units for each table row and each reset read
    localparam int WATCHDOG_TIME = (NUM_ROWS + NUM_VREGS + 8) * 10 * 4;

    // operand b source
    localparam logic [1:0] S_VS1 = 2'd0;
    localparam logic [1:0] S_RS1 = 2'd1;
    localparam logic [1:0] S_IMM = 2'd2;

    typedef struct packed {
        valuop_t        op;
        vfu_t           fu;
        vreg_idx_t      vs1;
        vreg_idx_t      vs2;
        vreg_idx_t      vd;
        logic [1:0]     src;
        logic           men;
        logic [VLW-1:0] vl;
        logic [2:0]     stall_cyc;
    } stim_t;

    // op, unit, vs1, vs2, vd, operand b, mask enable, vl, stall cycles
    localparam stim_t STIM [NUM_ROWS] = '{
        '{VALU_ADD,  VFU_ALU, 5'd0,  5'd1,  5'd1,  S_RS1, 1'b0, 3'd4, 3'd0},
        '{VALU_ADD,  VFU_ALU, 5'd0,  5'd2,  5'd2,  S_IMM, 1'b0, 3'd4, 3'd0},
        '{VALU_SUB,  VFU_ALU, 5'd1,  5'd2,  5'd3,  S_VS1, 1'b0, 3'd4, 3'd0},
        '{VALU_XOR,  VFU_ALU, 5'd3,  5'd1,  5'd4,  S_VS1, 1'b0, 3'd4, 3'd0},
        '{VALU_AND,  VFU_ALU, 5'd0,  5'd3,  5'd5,  S_RS1, 1'b0, 3'd4, 3'd0},
        '{VALU_OR,   VFU_ALU, 5'd0,  5'd4,  5'd6,  S_IMM, 1'b0, 3'd4, 3'd0},
        '{VALU_MIN,  VFU_ALU, 5'd1,  5'd3,  5'd7,  S_VS1, 1'b0, 3'd4, 3'd0},
        '{VALU_MAX,  VFU_ALU, 5'd1,  5'd3,  5'd8,  S_VS1, 1'b0, 3'd4, 3'd0},
        '{VALU_MINU, VFU_ALU, 5'd0,  5'd4,  5'd9,  S_RS1, 1'b0, 3'd4, 3'd0},
        '{VALU_MAXU, VFU_ALU, 5'd2,  5'd4,  5'd10, S_VS1, 1'b0, 3'd4, 3'd0},
        '{VALU_SEQ,  VFU_ALU, 5'd1,  5'd1,  5'd11, S_VS1, 1'b0, 3'd4, 3'd0},
        '{VALU_SEQ,  VFU_ALU, 5'd0,  5'd2,  5'd12, S_IMM, 1'b0, 3'd4, 3'd0},
        '{VALU_XOR,  VFU_ALU, 5'd0,  5'd0,  5'd0,  S_RS1, 1'b0, 3'd4, 3'd0},
        '{VALU_ADD,  VFU_ALU, 5'd1,  5'd2,  5'd3,  S_VS1, 1'b1, 3'd3, 3'd0},
        '{VALU_SUB,  VFU_ALU, 5'd0,  5'd4,  5'd4,  S_RS1, 1'b1, 3'd2, 3'd0},
        '{VALU_OR,   VFU_ALU, 5'd3,  5'd3,  5'd13, S_VS1, 1'b0, 3'd4, 3'd0},
        '{VALU_ADD,  VFU_RED, 5'd1,  5'd2,  5'd14, S_VS1, 1'b1, 3'd4, 3'd0},
        '{VALU_AND,  VFU_RED, 5'd5,  5'd1,  5'd15, S_VS1, 1'b0, 3'd3, 3'd0},
        '{VALU_OR,   VFU_RED, 5'd3,  5'd4,  5'd16, S_VS1, 1'b1, 3'd3, 3'd0},
        '{VALU_XOR,  VFU_RED, 5'd2,  5'd6,  5'd17, S_VS1, 1'b0, 3'd2, 3'd0},
        '{VALU_MIN,  VFU_RED, 5'd7,  5'd3,  5'd18, S_VS1, 1'b1, 3'd4, 3'd0},
        '{VALU_MAX,  VFU_RED, 5'd1,  5'd4,  5'd19, S_VS1, 1'b0, 3'd3, 3'd0},
        '{VALU_MINU, VFU_RED, 5'd2,  5'd6,  5'd20, S_VS1, 1'b1, 3'd4, 3'd0},
        '{VALU_MAXU, VFU_RED, 5'd1,  5'd3,  5'd21, S_VS1, 1'b0, 3'd1, 3'd0},
        '{VALU_ADD,  VFU_ALU, 5'd0,  5'd21, 5'd22, S_RS1, 1'b0, 3'd4, 3'd3},
        '{VALU_MAX,  VFU_ALU, 5'd22, 5'd21, 5'd23, S_VS1, 1'b0, 3'd4, 3'd2},
        '{VALU_ADD,  VFU_ALU, 5'd23, 5'd22, 5'd24, S_VS1, 1'b1, 3'd3, 3'd0},
        '{VALU_OR,   VFU_ALU, 5'd24, 5'd24, 5'd24, S_VS1, 1'b0, 3'd4, 3'd1}
    };

    logic                    CLK;
    logic                    rst_n;
    logic                    vvalid;
    vfu_t                    vfu;
    valuop_t                 valuop;
    vreg_idx_t               vs1_sel;
    vreg_idx_t               vs2_sel;
    vreg_idx_t               vd_sel;
    logic                    vxin1_use_imm;
    logic                    vxin1_use_rs1;
    vimm_t                   vimm;
    word_t                   rdat1;
    logic                    vmask_en;
    logic [VLW-1:0]          vl;
    logic                    stall;
    logic                    res_valid;
    vreg_idx_t               res_vd;
    logic [32*NUM_LANES-1:0] res_data;
    logic [NUM_LANES-1:0]    res_lane_mask;

    // reference copy of the register file
    word_t                   mreg [NUM_VREGS][NUM_LANES];
    logic [31:0]             lfsr;
    int                      errors;
    int                      checks;
    logic                    pending;
    logic [32*NUM_LANES-1:0] exp_data;
    logic [NUM_LANES-1:0]    exp_mask;
    vreg_idx_t               exp_vd;
    string                   exp_name;

    vex_top #(.NUM_LANES(NUM_LANES)) UUT (.*);

    always #2 CLK = ~CLK;

    // galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic word_t ref_op(valuop_t op, word_t a, word_t b);
        case (op)
            VALU_ADD:  return a + b;
            VALU_SUB:  return a - b;
            VALU_AND:  return a & b;
            VALU_OR:   return a | b;
            VALU_XOR:  return a ^ b;
            VALU_MIN:  return ($signed(a) <= $signed(b)) ? a : b;
            VALU_MAX:  return ($signed(a) >= $signed(b)) ? a : b;
            VALU_MINU: return (a <= b) ? a : b;
            VALU_MAXU: return (a >= b) ? a : b;
            VALU_SEQ:  return (a == b) ? 32'd1 : 32'd0;
            default:   return 32'd0;
        endcase
    endfunction

    task automatic check(input string name, input logic [127:0] exp, input logic [127:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("[FAIL] %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_result();
        if (pending) begin
            check({exp_name, " valid"}, 128'd1, 128'(res_valid));
            check({exp_name, " vd"}, 128'(exp_vd), 128'(res_vd));
            check({exp_name, " lane mask"}, 128'(exp_mask), 128'(res_lane_mask));
            check({exp_name, " data"}, exp_data, res_data);
        end
    endtask

    task automatic issue(input stim_t s, input string name);
        word_t                   rs1_val;
        word_t                   imm_ext;
        word_t                   opb;
        word_t                   acc;
        logic [4:0]              imm_val;
        logic [NUM_LANES-1:0]    act;
        logic [NUM_LANES-1:0]    wmask;
        logic [32*NUM_LANES-1:0] data;
        logic [137:0]            snap;
        rs1_val = rand_bits(32);
        imm_val = 5'(rand_bits(5));
        imm_ext = {{27{imm_val[4]}}, imm_val};
        @(posedge CLK);
        vvalid <= 1'b1;
        vfu <= s.fu;
        valuop <= s.op;
        vs1_sel <= s.vs1;
        vs2_sel <= s.vs2;
        vd_sel <= s.vd;
        vxin1_use_imm <= (s.src == S_IMM);
        vxin1_use_rs1 <= (s.src == S_RS1);
        vimm <= imm_val;
        rdat1 <= rs1_val;
        vmask_en <= s.men;
        vl <= s.vl;
        stall <= (s.stall_cyc != 0);
        // lanes below vl and enabled by v0 element 0 when masking
        for (int l = 0; l < NUM_LANES; l++) begin
            act[l] = (l < s.vl) && (!s.men || mreg[0][0][l]);
            data[32*l +: 32] = mreg[s.vd][l];
        end
        if (s.fu == VFU_RED) begin
            wmask = '0;
            wmask[0] = (s.vl != 0);
            acc = mreg[s.vs1][0];
            for (int l = 0; l < NUM_LANES; l++) begin
                if (act[l]) begin
                    acc = ref_op(s.op, acc, mreg[s.vs2][l]);
                end
            end
            if (wmask[0]) begin
                data[31:0] = acc;
            end
        end else begin
            wmask = act;
            for (int l = 0; l < NUM_LANES; l++) begin
                opb = (s.src == S_IMM) ? imm_ext : (s.src == S_RS1) ? rs1_val : mreg[s.vs1][l];
                if (act[l]) begin
                    data[32*l +: 32] = ref_op(s.op, mreg[s.vs2][l], opb);
                end
            end
        end
        for (int l = 0; l < NUM_LANES; l++) begin
            if (wmask[l]) begin
                mreg[s.vd][l] = data[32*l +: 32];
            end
        end
        @(negedge CLK);
        check_result();
        pending = 1'b1;
        exp_name = name;
        exp_vd = s.vd;
        exp_mask = wmask;
        exp_data = data;
        snap = {res_valid, res_vd, res_lane_mask, res_data};
        // previous result must sit still while this one waits
        for (int k = 0; k < s.stall_cyc; k++) begin
            @(posedge CLK);
            if (k == s.stall_cyc - 1) begin
                stall <= 1'b0;
            end
            @(negedge CLK);
            check({name, " stalled data"}, snap[127:0], res_data);
            check({name, " stalled control"}, 128'(snap[137:128]),
                  128'({res_valid, res_vd, res_lane_mask}));
        end
    endtask

    initial begin
        #(WATCHDOG_TIME);
        $display("timeout: the test sequence did not finish in time");
        $display("Simulation failed");
        $finish;
    end

    initial begin
        stim_t s;
        errors = 0;
        checks = 0;
        pending = 1'b0;
        lfsr = 32'h4dc058e1;
        CLK = 1'b0;
        rst_n = 1'b0;
        vvalid = 1'b0;
        vfu = VFU_ALU;
        valuop = VALU_ADD;
        vs1_sel = '0;
        vs2_sel = '0;
        vd_sel = '0;
        vxin1_use_imm = 1'b0;
        vxin1_use_rs1 = 1'b0;
        vimm = '0;
        rdat1 = '0;
        vmask_en = 1'b0;
        vl = '0;
        stall = 1'b0;
        for (int r = 0; r < NUM_VREGS; r++) begin
            for (int l = 0; l < NUM_LANES; l++) begin
                mreg[r][l] = '0;
            end
        end
        repeat (3) @(posedge CLK);
        rst_n <= 1'b1;
        @(negedge CLK);
        check("reset valid", 128'd0, 128'(res_valid));
        // every register reads back as zero after reset
        for (int r = 0; r < NUM_VREGS; r++) begin
            s = '{VALU_OR, VFU_ALU, 5'(r), 5'(r), 5'(r), S_VS1, 1'b0, 3'd4, 3'd0};
            issue(s, $sformatf("reset read v%0d", r));
        end
        for (int i = 0; i < NUM_ROWS; i++) begin
            s = STIM[i];
            issue(s, $sformatf("row %0d %s", i, s.op.name()));
        end
        @(posedge CLK);
        vvalid <= 1'b0;
        @(negedge CLK);
        check_result();
        pending = 1'b0;
        @(negedge CLK);
        check("idle valid", 128'd0, 128'(res_valid));
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: build.f
src/vex_pkg.sv
src/vex_if.sv
src/vector_bank.sv
src/vlane_alu.sv
src/vreduction_unit.sv
src/vex_datapath.sv
src/vex_mem_reg.sv
src/vex_top.sv
tb/vex_properties.sv
tb/vex_tb.sv

// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := vex_tb
FILELIST := build.f
OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
SOURCES  := $(shell cat $(FILELIST))
PASS_MSG := Simulation completed successfully

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
